// File: hw/radio_pkg.sv
package radio_pkg;

   //----------------------------------------
   // widths
   //----------------------------------------
   localparam int SAMPLE_W  = 32;
   localparam int IQ_W      = 16;
   localparam int FP_GPIO_W = 12;
   localparam int ADDR_W    = 8;

   //----------------------------------------
   // settings bus map
   //----------------------------------------
   localparam logic [ADDR_W-1:0] SR_TAG_BASE       = 8'd160;  // pattern, amp, symb_len, ddr
   localparam logic [ADDR_W-1:0] SR_TX_FE_BASE     = 8'd208;  // source, then dc offset
   localparam logic [ADDR_W-1:0] SR_FE_CHAN_OFFSET = 8'd16;   // stride between radios

   localparam logic [IQ_W-1:0] DEFAULT_TAG_AMP = 16'h4000;

   // one dac word, i in the upper half
   typedef struct packed {
      logic signed [IQ_W-1:0] i;
      logic signed [IQ_W-1:0] q;
   } iq_t;

   typedef union packed {
      logic [SAMPLE_W-1:0] raw;
      iq_t                 iq;
   } sample_t;

   typedef struct packed {
      logic              stb;
      logic [ADDR_W-1:0] addr;
      logic [31:0]       data;
   } set_bus_t;

   typedef struct packed {
      logic    valid;
      sample_t data;
   } tx_stream_t;

   typedef struct packed {
      logic [15:0]          pattern;   // low NUM_SYMB bits used
      logic [IQ_W-1:0]      amp;       // unsigned magnitude
      logic [7:0]           symb_len;  // hold is symb_len+1 strobes
      logic [FP_GPIO_W-1:0] gpio_ddr;
   } tag_cfg_t;

   typedef struct packed {
      logic    src_host;  // 0 selects the tag stream
      sample_t dc_offset;
   } fe_cfg_t;

endpackage

// File: hw/settings_regs.sv
module settings_regs import radio_pkg::*; #(
   parameter int NUM_RADIOS = 2
) (
   input  logic                  radio_clk,
   input  logic                  i_reset,
   input  set_bus_t              i_set,
   output tag_cfg_t              o_tag_cfg,
   output logic                  o_tag_restart,
   output fe_cfg_t               o_fe_cfg [NUM_RADIOS],
   output logic [NUM_RADIOS-1:0] o_fe_clear
);

   //----------------------------------------
   // tag modulator registers
   //----------------------------------------
   logic hit_pattern;
   logic hit_amp;
   logic hit_symb_len;
   logic hit_gpio_ddr;

   assign hit_pattern  = i_set.stb && (i_set.addr == SR_TAG_BASE);
   assign hit_amp      = i_set.stb && (i_set.addr == SR_TAG_BASE + 8'd1);
   assign hit_symb_len = i_set.stb && (i_set.addr == SR_TAG_BASE + 8'd2);
   assign hit_gpio_ddr = i_set.stb && (i_set.addr == SR_TAG_BASE + 8'd3);

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_tag_cfg.pattern  <= '0;
         o_tag_cfg.amp      <= DEFAULT_TAG_AMP;
         o_tag_cfg.symb_len <= '0;
         o_tag_cfg.gpio_ddr <= '0;
         o_tag_restart      <= 1'b0;
      end else begin
         if (hit_pattern)  o_tag_cfg.pattern  <= i_set.data[15:0];
         if (hit_amp)      o_tag_cfg.amp      <= i_set.data[IQ_W-1:0];
         if (hit_symb_len) o_tag_cfg.symb_len <= i_set.data[7:0];
         if (hit_gpio_ddr) o_tag_cfg.gpio_ddr <= i_set.data[FP_GPIO_W-1:0];
         // a new pattern or symbol length starts again from symbol 0
         o_tag_restart <= hit_pattern || hit_symb_len;
      end
   end

   //----------------------------------------
   // per-radio front end registers
   //----------------------------------------
   for (genvar r = 0; r < NUM_RADIOS; r++) begin : g_fe_regs
      localparam logic [ADDR_W-1:0] SRC_ADDR =
         ADDR_W'(SR_TX_FE_BASE + r * SR_FE_CHAN_OFFSET);
      localparam logic [ADDR_W-1:0] OFFSET_ADDR = SRC_ADDR + 8'd1;

      logic hit_src;
      logic hit_offset;

      assign hit_src    = i_set.stb && (i_set.addr == SRC_ADDR);
      assign hit_offset = i_set.stb && (i_set.addr == OFFSET_ADDR);

      always_ff @(posedge radio_clk) begin
         if (i_reset) begin
            o_fe_cfg[r].src_host  <= 1'b0;  // tag by default
            o_fe_cfg[r].dc_offset <= '0;
            o_fe_clear[r]         <= 1'b0;
         end else begin
            if (hit_src)    o_fe_cfg[r].src_host  <= i_set.data[0];
            if (hit_offset) o_fe_cfg[r].dc_offset <= i_set.data;
            o_fe_clear[r] <= hit_src;  // source write also drops the underrun flag
         end
      end
   end

endmodule

// File: hw/tag_symbol_gen.sv
module tag_symbol_gen import radio_pkg::*; #(
   parameter int NUM_SYMB = 9
) (
   input  logic                 radio_clk,
   input  logic                 i_reset,
   input  tag_cfg_t             i_cfg,
   input  logic                 i_restart,
   input  logic                 i_dac_stb,
   output sample_t              o_tag_sample,
   output logic [FP_GPIO_W-1:0] o_fp_gpio_out,
   output logic [FP_GPIO_W-1:0] o_fp_gpio_ddr
);

   localparam int IDX_W = (NUM_SYMB > 1) ? $clog2(NUM_SYMB) : 1;
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_SYMB - 1);

   logic [IDX_W-1:0] symb_idx;
   logic [7:0]       hold_cnt;
   logic [IDX_W-1:0] cur_idx;
   logic [7:0]       cur_hold;
   logic             symb_bit;
   logic             last_hold;
   logic             last_symb;

   //----------------------------------------
   // current symbol
   //----------------------------------------
   // a restart coincident with a strobe makes that strobe symbol 0
   assign cur_idx  = i_restart ? '0 : symb_idx;
   assign cur_hold = i_restart ? '0 : hold_cnt;

   assign symb_bit  = i_cfg.pattern[cur_idx];
   assign last_hold = (cur_hold == i_cfg.symb_len);
   assign last_symb = (cur_idx == LAST_IDX);

   always_comb begin
      o_tag_sample.iq.i = symb_bit ? i_cfg.amp : ~i_cfg.amp + 1'b1;  // +/- amp
      o_tag_sample.iq.q = '0;
   end

   //----------------------------------------
   // symbol index and hold counter
   //----------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         symb_idx <= '0;
         hold_cnt <= '0;
      end else if (i_dac_stb) begin
         if (last_hold) begin
            hold_cnt <= '0;
            symb_idx <= last_symb ? '0 : cur_idx + 1'b1;  // wrap after NUM_SYMB
         end else begin
            hold_cnt <= cur_hold + 1'b1;
            symb_idx <= cur_idx;
         end
      end else if (i_restart) begin
         symb_idx <= '0;
         hold_cnt <= '0;
      end
   end

   //----------------------------------------
   // front-panel gpio
   //----------------------------------------
   // lines up with o_tx, one cycle after the strobe
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         o_fp_gpio_ddr <= i_cfg.gpio_ddr;
         if (i_dac_stb) begin
            o_fp_gpio_out <= {{(FP_GPIO_W-2){1'b0}}, (cur_hold == 8'd0), symb_bit};
         end
      end
   end

endmodule

// File: hw/tx_frontend.sv
module tx_frontend import radio_pkg::*; (
   input  logic       radio_clk,
   input  logic       i_reset,
   input  fe_cfg_t    i_cfg,
   input  logic       i_clear,
   input  logic       i_dac_stb,
   input  sample_t    i_tag_sample,
   input  tx_stream_t i_host,
   output logic       o_host_ready,
   output sample_t    o_tx,
   output logic       o_tx_valid,
   output logic       o_underrun
);

   sample_t src_sample;
   sample_t corr_sample;
   logic    host_miss;

   // add with clamp to the signed component range
   function automatic logic signed [IQ_W-1:0] sat_add(
      input logic signed [IQ_W-1:0] a,
      input logic signed [IQ_W-1:0] b
   );
      logic signed [IQ_W:0] sum;
      sum = $signed({a[IQ_W-1], a}) + $signed({b[IQ_W-1], b});
      if (sum[IQ_W] != sum[IQ_W-1]) begin
         return sum[IQ_W] ? {1'b1, {(IQ_W-1){1'b0}}} : {1'b0, {(IQ_W-1){1'b1}}};
      end
      return sum[IQ_W-1:0];
   endfunction

   //----------------------------------------
   // source select
   //----------------------------------------
   assign o_host_ready = i_dac_stb && i_cfg.src_host;  // host only sampled on a strobe
   assign host_miss    = o_host_ready && !i_host.valid;

   always_comb begin
      if (!i_cfg.src_host) begin
         src_sample = i_tag_sample;
      end else if (i_host.valid) begin
         src_sample = i_host.data;
      end else begin
         src_sample = '0;  // starved, send only the offset
      end
   end

   //----------------------------------------
   // dc offset and output
   //----------------------------------------
   always_comb begin
      corr_sample.iq.i = sat_add(src_sample.iq.i, i_cfg.dc_offset.iq.i);
      corr_sample.iq.q = sat_add(src_sample.iq.q, i_cfg.dc_offset.iq.q);
   end

   always_ff @(posedge radio_clk) begin
      if (i_dac_stb) o_tx <= corr_sample;
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_tx_valid <= 1'b0;
         o_underrun <= 1'b0;
      end else begin
         o_tx_valid <= i_dac_stb;
         if (host_miss) begin
            o_underrun <= 1'b1;  // sticky
         end else if (i_clear) begin
            o_underrun <= 1'b0;
         end
      end
   end

endmodule

// File: hw/x300_tag_radio.sv
module x300_tag_radio import radio_pkg::*; #(
   parameter int NUM_RADIOS = 2,
   parameter int NUM_SYMB   = 9
) (
   input  logic                  radio_clk,
   input  logic                  i_reset,
   input  set_bus_t              i_set,
   input  logic                  i_dac_stb,
   input  tx_stream_t            i_host_tx [NUM_RADIOS],
   output logic [NUM_RADIOS-1:0] o_host_ready,
   output sample_t               o_tx [NUM_RADIOS],
   output logic                  o_tx_valid,
   output logic [NUM_RADIOS-1:0] o_underrun,
   output logic [FP_GPIO_W-1:0]  o_fp_gpio_out,
   output logic [FP_GPIO_W-1:0]  o_fp_gpio_ddr
);

   tag_cfg_t              tag_cfg;
   logic                  tag_restart;
   sample_t               tag_sample;
   fe_cfg_t               fe_cfg [NUM_RADIOS];
   logic [NUM_RADIOS-1:0] fe_clear;
   logic [NUM_RADIOS-1:0] fe_tx_valid;

   //----------------------------------------
   // settings
   //----------------------------------------
   settings_regs #(
      .NUM_RADIOS (NUM_RADIOS)
   ) settings_regs_i (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .i_set         (i_set),
      .o_tag_cfg     (tag_cfg),
      .o_tag_restart (tag_restart),
      .o_fe_cfg      (fe_cfg),
      .o_fe_clear    (fe_clear)
   );

   //----------------------------------------
   // tag modulator, shared by both radios
   //----------------------------------------
   tag_symbol_gen #(
      .NUM_SYMB (NUM_SYMB)
   ) tag_symbol_gen_i (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .i_cfg         (tag_cfg),
      .i_restart     (tag_restart),
      .i_dac_stb     (i_dac_stb),
      .o_tag_sample  (tag_sample),
      .o_fp_gpio_out (o_fp_gpio_out),
      .o_fp_gpio_ddr (o_fp_gpio_ddr)
   );

   //----------------------------------------
   // per-radio tx front ends
   //----------------------------------------
   for (genvar r = 0; r < NUM_RADIOS; r++) begin : g_radio
      tx_frontend tx_frontend_i (
         .radio_clk    (radio_clk),
         .i_reset      (i_reset),
         .i_cfg        (fe_cfg[r]),
         .i_clear      (fe_clear[r]),
         .i_dac_stb    (i_dac_stb),
         .i_tag_sample (tag_sample),
         .i_host       (i_host_tx[r]),
         .o_host_ready (o_host_ready[r]),
         .o_tx         (o_tx[r]),
         .o_tx_valid   (fe_tx_valid[r]),
         .o_underrun   (o_underrun[r])
      );
   end

   // all radios share the strobe, so their valids are identical
   assign o_tx_valid = fe_tx_valid[0];

endmodule

// File: verification/tb_x300_tag_radio.sv
module tb_x300_tag_radio import radio_pkg::*; ();

   localparam int NUM_RADIOS = 2;
   localparam int NUM_SYMB   = 9;

   typedef struct packed {
      logic [FP_GPIO_W-1:0]        gpio;
      logic [NUM_RADIOS-1:0][31:0] tx;
   } expect_t;

   logic                  radio_clk;
   logic                  i_reset;
   set_bus_t              i_set;
   logic                  i_dac_stb;
   tx_stream_t            i_host_tx [NUM_RADIOS];
   logic [NUM_RADIOS-1:0] o_host_ready;
   sample_t               o_tx [NUM_RADIOS];
   logic                  o_tx_valid;
   logic [NUM_RADIOS-1:0] o_underrun;
   logic [FP_GPIO_W-1:0]  o_fp_gpio_out;
   logic [FP_GPIO_W-1:0]  o_fp_gpio_ddr;

   // model of the configuration as written so far
   logic [15:0]          t_pattern;
   logic [15:0]          t_amp;
   logic [7:0]           t_symb_len;
   logic [FP_GPIO_W-1:0] t_ddr;
   logic                 t_src [NUM_RADIOS];
   logic [31:0]          t_offset [NUM_RADIOS];
   int                   n_stb;       // strobes since last restart
   expect_t              exp_q [$];
   logic                 stb_prev;
   integer               seed;
   int                   errors;
   int                   checks;
   int                   err_mark;

   x300_tag_radio #(
      .NUM_RADIOS (NUM_RADIOS),
      .NUM_SYMB   (NUM_SYMB)
   ) x300_tag_radio_i (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .i_set         (i_set),
      .i_dac_stb     (i_dac_stb),
      .i_host_tx     (i_host_tx),
      .o_host_ready  (o_host_ready),
      .o_tx          (o_tx),
      .o_tx_valid    (o_tx_valid),
      .o_underrun    (o_underrun),
      .o_fp_gpio_out (o_fp_gpio_out),
      .o_fp_gpio_ddr (o_fp_gpio_ddr)
   );

   initial begin
      radio_clk = 1'b0;
      forever #5 radio_clk = ~radio_clk;
   end

   //----------------------------------------
   // reference model
   //----------------------------------------
   function automatic int clamp16(input int v);
      if (v > 32767) return 32767;
      if (v < -32768) return -32768;
      return v;
   endfunction

   function automatic logic [31:0] ref_sample(input int r, input int n,
                                              input logic hv, input logic [31:0] hd);
      int idx;
      int si;
      int sq;
      int oi;
      int oq;
      idx = (n / (int'(t_symb_len) + 1)) % NUM_SYMB;
      if (t_src[r]) begin
         si = hv ? int'($signed(hd[31:16])) : 0;  // starved host sends zero
         sq = hv ? int'($signed(hd[15:0])) : 0;
      end else begin
         si = t_pattern[idx] ? int'(t_amp) : -int'(t_amp);
         sq = 0;
      end
      oi = clamp16(si + int'($signed(t_offset[r][31:16])));
      oq = clamp16(sq + int'($signed(t_offset[r][15:0])));
      return {oi[15:0], oq[15:0]};
   endfunction

   function automatic logic [FP_GPIO_W-1:0] ref_gpio(input int n);
      int idx;
      logic first;
      idx   = (n / (int'(t_symb_len) + 1)) % NUM_SYMB;
      first = (n % (int'(t_symb_len) + 1)) == 0;
      return {{(FP_GPIO_W-2){1'b0}}, first, t_pattern[idx]};
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
      checks++;
      if (exp !== got) begin
         $display("Fail %0s exp %h got %h", name, exp, got);
         errors++;
      end
   endtask

   //----------------------------------------
   // comparing process
   //----------------------------------------
   always @(posedge radio_clk) stb_prev <= i_dac_stb;

   always @(negedge radio_clk) begin : compare_outputs
      expect_t e;
      if (!i_reset) begin
         check("o_tx_valid", stb_prev, o_tx_valid);
         for (int r = 0; r < NUM_RADIOS; r++) begin
            check($sformatf("o_host_ready[%0d]", r), i_dac_stb & t_src[r], o_host_ready[r]);
         end
         if (o_tx_valid) begin
            if (exp_q.size() == 0) begin
               $display("output sample arrived with no expected value queued");
               errors++;
            end else begin
               e = exp_q.pop_front();
               for (int r = 0; r < NUM_RADIOS; r++) begin
                  check($sformatf("o_tx[%0d]", r), e.tx[r], o_tx[r].raw);
               end
               check("o_fp_gpio_out", e.gpio, o_fp_gpio_out);
               check("o_fp_gpio_ddr", t_ddr, o_fp_gpio_ddr);
            end
         end
      end
   end

   //----------------------------------------
   // stimulus helpers
   //----------------------------------------
   task automatic step();
      @(posedge radio_clk);
      #1;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      logic [7:0] fe_addr;
      i_set.stb  = 1'b1;
      i_set.addr = addr;
      i_set.data = data;
      step();
      i_set.stb = 1'b0;
      if (addr == SR_TAG_BASE) begin
         t_pattern = data[15:0];
         n_stb     = 0;  // restart
      end else if (addr == SR_TAG_BASE + 8'd1) begin
         t_amp = data[15:0];
      end else if (addr == SR_TAG_BASE + 8'd2) begin
         t_symb_len = data[7:0];
         n_stb      = 0;
      end else if (addr == SR_TAG_BASE + 8'd3) begin
         t_ddr = data[FP_GPIO_W-1:0];
      end
      for (int r = 0; r < NUM_RADIOS; r++) begin
         fe_addr = 8'(SR_TX_FE_BASE + r * SR_FE_CHAN_OFFSET);
         if (addr == fe_addr) t_src[r] = data[0];
         if (addr == fe_addr + 8'd1) t_offset[r] = data;
      end
      step();  // restart and ddr settle
      step();
   endtask

   task automatic send_strobe();
      expect_t e;
      int      gap;
      gap = {$random(seed)} % 3;
      repeat (gap) step();
      i_dac_stb = 1'b1;
      for (int r = 0; r < NUM_RADIOS; r++) begin
         e.tx[r] = ref_sample(r, n_stb, i_host_tx[r].valid, i_host_tx[r].data.raw);
      end
      e.gpio = ref_gpio(n_stb);
      exp_q.push_back(e);
      n_stb++;
      step();
      i_dac_stb = 1'b0;
      for (int r = 0; r < NUM_RADIOS; r++) begin
         if (t_src[r] && i_host_tx[r].valid) i_host_tx[r].data.raw = $random(seed);  // next
      end
   endtask

   task automatic wait_drained(input string what);
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0 && cycles < 50) begin
         step();
         cycles++;
      end
      if (exp_q.size() != 0) begin
         $display("timeout: expected outputs never arrived in %0s", what);
         $display("sim failed");
         $finish;
      end
   endtask

   task automatic run_strobes(input int count, input string what);
      repeat (count) send_strobe();
      wait_drained(what);
   endtask

   task automatic end_test(input string name);
      $display("test %0s: %0s (%0d errors)", name,
               (errors == err_mark) ? "ok" : "mismatch", errors - err_mark);
      err_mark = errors;
   endtask

   //----------------------------------------
   // main sequence
   //----------------------------------------
   initial begin : main
      int cycles;
      seed       = 32'h14e4;
      errors     = 0;
      checks     = 0;
      err_mark   = 0;
      stb_prev   = 1'b0;
      t_pattern  = '0;
      t_amp      = DEFAULT_TAG_AMP;
      t_symb_len = '0;
      t_ddr      = '0;
      n_stb      = 0;
      i_reset    = 1'b1;
      i_set      = '0;
      i_dac_stb  = 1'b0;
      for (int r = 0; r < NUM_RADIOS; r++) begin
         t_src[r]     = 1'b0;
         t_offset[r]  = '0;
         i_host_tx[r] = '0;
      end
      repeat (10) @(posedge radio_clk);
      #1 i_reset = 1'b0;

      check("o_fp_gpio_ddr", 0, o_fp_gpio_ddr);
      run_strobes(20, "reset defaults");
      check("o_underrun", 0, o_underrun);
      end_test("reset defaults");

      write_reg(SR_TAG_BASE, {$random(seed)} & 32'h1ff);
      write_reg(SR_TAG_BASE + 8'd1, 32'h2345);
      write_reg(SR_TAG_BASE + 8'd2, 32'd2);
      run_strobes(3 * NUM_SYMB * 3, "tag pattern");  // three pattern periods
      end_test("tag pattern");

      write_reg(SR_TX_FE_BASE + 8'd1, $random(seed));
      write_reg(SR_TX_FE_BASE + SR_FE_CHAN_OFFSET + 8'd1, $random(seed));
      run_strobes(20, "dc offset");
      write_reg(SR_TX_FE_BASE + 8'd1, {16'h7fff, 16'h8000});  // extremes
      write_reg(SR_TX_FE_BASE + SR_FE_CHAN_OFFSET + 8'd1, {16'h8000, 16'h7fff});
      run_strobes(20, "dc offset");
      end_test("dc offset");

      write_reg(SR_TX_FE_BASE + SR_FE_CHAN_OFFSET + 8'd1, $random(seed));
      i_host_tx[1].valid    = 1'b1;
      i_host_tx[1].data.raw = $random(seed);
      write_reg(SR_TX_FE_BASE + SR_FE_CHAN_OFFSET, 32'd1);  // radio 1 on host
      run_strobes(30, "host source");
      check("o_underrun", 0, o_underrun);
      end_test("host source");

      i_host_tx[1].valid = 1'b0;  // starve one strobe
      send_strobe();
      i_host_tx[1].valid = 1'b1;
      run_strobes(5, "underrun");
      check("o_underrun", 2'b10, o_underrun);
      write_reg(SR_TX_FE_BASE + SR_FE_CHAN_OFFSET, 32'd1);
      cycles = 0;
      while (o_underrun[1] && cycles < 20) begin
         step();
         cycles++;
      end
      if (o_underrun[1]) begin
         $display("timeout: underrun flag of radio 1 never cleared");
         $display("sim failed");
         $finish;
      end
      check("o_underrun", 0, o_underrun);
      end_test("underrun");

      write_reg(SR_TAG_BASE + 8'd3, {$random(seed)} & 32'hfff);
      write_reg(SR_TX_FE_BASE + SR_FE_CHAN_OFFSET, 32'd0);  // radio 1 back on tag
      write_reg(SR_TAG_BASE + 8'd2, 32'd1);
      write_reg(SR_TAG_BASE, {$random(seed)} & 32'h1ff);
      run_strobes(2 * NUM_SYMB * 2, "gpio");
      check("o_fp_gpio_ddr", t_ddr, o_fp_gpio_ddr);
      end_test("gpio");

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: x300_tag_radio.f
hw/radio_pkg.sv
hw/settings_regs.sv
hw/tag_symbol_gen.sv
hw/tx_frontend.sv
hw/x300_tag_radio.sv
verification/tb_x300_tag_radio.sv
